/* gpu_consts.svh */
// Widths and counts shared by the core; changing the lane count also changes the top-level port arrays
`ifndef GPU_CONSTS_SVH
`define GPU_CONSTS_SVH

// Data path and register width
`define GPU_DATA_W 8

// Program and data memory address width
`define GPU_ADDR_W 8

// One instruction word, opcode in the top nibble
`define GPU_INSTR_W 16

// Thread lanes per core, one thread each
`define GPU_LANES 4

// Registers per lane, the last three hold the block and thread identity
`define GPU_REGS 16

// Bits needed to name one register
`define GPU_REG_IDX_W 4

`endif

/* gpu_pkg.sv */
// Types for the compute core; opcode values match instruction bits 15 to 12 and unknown values act as NOP
`include "gpu_consts.svh"

package gpu_pkg;

    // Core control sequence, one state per pipeline step
    typedef enum logic [2:0] {
        CORE_IDLE    = 3'd0,
        CORE_FETCH   = 3'd1,
        CORE_DECODE  = 3'd2,
        CORE_REQUEST = 3'd3,
        CORE_WAIT    = 3'd4,
        CORE_EXECUTE = 3'd5,
        CORE_UPDATE  = 3'd6,
        CORE_DONE    = 3'd7
    } core_state_t;

    typedef enum logic [1:0] {
        FETCH_IDLE = 2'd0,
        FETCHING   = 2'd1,
        FETCHED    = 2'd2
    } fetch_state_t;

    typedef enum logic [1:0] {
        LSU_IDLE       = 2'd0,
        LSU_REQUESTING = 2'd1,
        LSU_WAITING    = 2'd2,
        LSU_DONE       = 2'd3
    } lsu_state_t;

    // Code 6 is free and decodes as NOP
    typedef enum logic [3:0] {
        OP_NOP   = 4'h0,
        OP_BRNZP = 4'h1,
        OP_CMP   = 4'h2,
        OP_ADD   = 4'h3,
        OP_SUB   = 4'h4,
        OP_MUL   = 4'h5,
        OP_LDR   = 4'h7,
        OP_STR   = 4'h8,
        OP_CONST = 4'h9,
        OP_RET   = 4'hf
    } opcode_t;

    // Source of the value written to rd in UPDATE
    typedef enum logic [1:0] {
        WB_ALU = 2'd0,
        WB_MEM = 2'd1,
        WB_IMM = 2'd2
    } wb_src_t;

    // The NZP mask is ordered n, z, p from the high bit down
    typedef struct packed {
        logic [`GPU_REG_IDX_W-1:0] rd;
        logic [`GPU_REG_IDX_W-1:0] rs;
        logic [`GPU_REG_IDX_W-1:0] rt;
        logic [`GPU_DATA_W-1:0]    imm;
        logic [2:0]                nzp;
        logic                      reg_write;
        logic                      mem_read;
        logic                      mem_write;
        logic                      nzp_write;
        logic                      branch;
        wb_src_t                   wb_src;
        opcode_t                   alu_op;
        logic                      ret;
    } decoded_t;

    typedef struct packed {
        logic                   read;
        logic                   write;
        logic [`GPU_ADDR_W-1:0] address;
        logic [`GPU_DATA_W-1:0] write_data;
    } mem_req_t;

endpackage

/* scheduler.sv */
// Assumes every enabled lane branches the same way; the PC follows the highest enabled lane
`timescale 1ns/1ps
`include "gpu_consts.svh"

module scheduler import gpu_pkg::*; (
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic                                  start,
    input  logic                                  decoded_ret,
    input  fetch_state_t                          fetch_state,
    input  lsu_state_t [`GPU_LANES-1:0]           lsu_state,
    input  logic [`GPU_LANES-1:0]                 lane_enable,
    input  logic [`GPU_LANES-1:0][`GPU_ADDR_W-1:0] next_pc,
    output logic [`GPU_ADDR_W-1:0]                current_pc,
    output core_state_t                           core_state,
    output logic                                  done
);

    logic                   lsu_busy;
    logic [`GPU_ADDR_W-1:0] top_pc;

    // Join of all enabled lanes that still have a memory access in flight
    always_comb begin
        lsu_busy = 1'b0;
        for (int i = 0; i < `GPU_LANES; i++) begin
            if (lane_enable[i] &&
                (lsu_state[i] == LSU_REQUESTING || lsu_state[i] == LSU_WAITING)) begin
                lsu_busy = 1'b1;
            end
        end
    end

    // Disabled lanes never write NZP, so their branch decision cannot be trusted
    always_comb begin
        top_pc = next_pc[0];
        for (int i = 1; i < `GPU_LANES; i++) begin
            if (lane_enable[i]) begin
                top_pc = next_pc[i];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            current_pc <= '0;
            core_state <= CORE_IDLE;
            done       <= 1'b0;
        end else begin
            case (core_state)
                CORE_IDLE: begin
                    if (start) begin
                        core_state <= CORE_FETCH;
                    end
                end
                // Program latency is absorbed here
                CORE_FETCH: begin
                    if (fetch_state == FETCHED) begin
                        core_state <= CORE_DECODE;
                    end
                end
                CORE_DECODE:  core_state <= CORE_REQUEST;
                CORE_REQUEST: core_state <= CORE_WAIT;
                // Zero extra cycles when no lane touches data memory
                CORE_WAIT: begin
                    if (!lsu_busy) begin
                        core_state <= CORE_EXECUTE;
                    end
                end
                CORE_EXECUTE: core_state <= CORE_UPDATE;
                CORE_UPDATE: begin
                    if (decoded_ret) begin
                        done       <= 1'b1;
                        core_state <= CORE_DONE;
                    end else begin
                        current_pc <= top_pc;
                        core_state <= CORE_FETCH;
                    end
                end
                // Parked until the next reset
                default: core_state <= CORE_DONE;
            endcase
        end
    end

endmodule

/* fetcher.sv */
// One program read per instruction; the memory must acknowledge at least one cycle after the request
`timescale 1ns/1ps
`include "gpu_consts.svh"

module fetcher import gpu_pkg::*; (
    input  logic                    clk,
    input  logic                    reset,
    input  core_state_t             core_state,
    input  logic [`GPU_ADDR_W-1:0]  current_pc,
    output logic                    program_read,
    output logic [`GPU_ADDR_W-1:0]  program_address,
    input  logic                    program_ack,
    input  logic [`GPU_INSTR_W-1:0] program_data,
    output fetch_state_t            fetch_state,
    output logic [`GPU_INSTR_W-1:0] instruction
);

    always_ff @(posedge clk) begin
        if (reset) begin
            fetch_state  <= FETCH_IDLE;
            program_read <= 1'b0;
        end else begin
            case (fetch_state)
                // The address is captured with the read level and held with it
                FETCH_IDLE: begin
                    if (core_state == CORE_FETCH) begin
                        program_read    <= 1'b1;
                        program_address <= current_pc;
                        fetch_state     <= FETCHING;
                    end
                end
                // Read data is only valid in the acknowledge cycle
                FETCHING: begin
                    if (program_ack) begin
                        instruction  <= program_data;
                        program_read <= 1'b0;
                        fetch_state  <= FETCHED;
                    end
                end
                // The word stays held after this, until the next fetch replaces it
                FETCHED: begin
                    if (core_state == CORE_DECODE) begin
                        fetch_state <= FETCH_IDLE;
                    end
                end
                default: fetch_state <= FETCH_IDLE;
            endcase
        end
    end

endmodule

/* decoder.sv */
// Register fields are taken from fixed bit positions for every opcode; unknown opcodes set no enables
`timescale 1ns/1ps
`include "gpu_consts.svh"

module decoder import gpu_pkg::*; (
    input  logic                    clk,
    input  logic                    reset,
    input  core_state_t             core_state,
    input  logic [`GPU_INSTR_W-1:0] instruction,
    output decoded_t                decoded
);

    opcode_t  op;
    decoded_t dec_d;

    always_comb begin
        op    = opcode_t'(instruction[15:12]);
        dec_d = '0;

        // Operand fields overlap, each instruction reads only the ones it needs
        dec_d.rd  = instruction[11:8];
        dec_d.rs  = instruction[7:4];
        dec_d.rt  = instruction[3:0];
        dec_d.imm = instruction[7:0];
        dec_d.nzp = instruction[11:9];

        case (op)
            OP_BRNZP: dec_d.branch = 1'b1;
            OP_CMP: begin
                dec_d.nzp_write = 1'b1;
                dec_d.alu_op    = OP_CMP;
            end
            OP_ADD, OP_SUB, OP_MUL: begin
                dec_d.reg_write = 1'b1;
                dec_d.wb_src    = WB_ALU;
                dec_d.alu_op    = op;
            end
            // Load writes rd with the word at the address in rs
            OP_LDR: begin
                dec_d.mem_read  = 1'b1;
                dec_d.reg_write = 1'b1;
                dec_d.wb_src    = WB_MEM;
            end
            // Store writes rt to the address in rs
            OP_STR:   dec_d.mem_write = 1'b1;
            OP_CONST: begin
                dec_d.reg_write = 1'b1;
                dec_d.wb_src    = WB_IMM;
            end
            OP_RET: dec_d.ret = 1'b1;
            // NOP and every unused code leave all enables low
            default: dec_d.alu_op = OP_NOP;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            decoded <= '0;
        end else if (core_state == CORE_DECODE) begin
            decoded <= dec_d;
        end
    end

endmodule

/* lsu.sv */
// One access per instruction; the request stays up until the cycle after the acknowledge
`timescale 1ns/1ps
`include "gpu_consts.svh"

module lsu import gpu_pkg::*; (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   enable,
    input  core_state_t            core_state,
    input  decoded_t               decoded,
    input  logic [`GPU_DATA_W-1:0] address,
    input  logic [`GPU_DATA_W-1:0] store_data,
    output mem_req_t               mem_req,
    input  logic                   mem_ack,
    input  logic [`GPU_DATA_W-1:0] mem_read_data,
    output logic [`GPU_DATA_W-1:0] load_data,
    output lsu_state_t             lsu_state
);

    always_ff @(posedge clk) begin
        if (reset) begin
            lsu_state     <= LSU_IDLE;
            mem_req.read  <= 1'b0;
            mem_req.write <= 1'b0;
        end else begin
            case (lsu_state)
                // A disabled lane never leaves IDLE
                LSU_IDLE: begin
                    if (core_state == CORE_REQUEST && enable &&
                        (decoded.mem_read || decoded.mem_write)) begin
                        lsu_state <= LSU_REQUESTING;
                    end
                end
                // Level goes up one cycle after REQUEST, the scheduler already sees us busy
                LSU_REQUESTING: begin
                    mem_req.read       <= decoded.mem_read;
                    mem_req.write      <= decoded.mem_write;
                    mem_req.address    <= address;
                    mem_req.write_data <= store_data;
                    lsu_state          <= LSU_WAITING;
                end
                LSU_WAITING: begin
                    if (mem_ack) begin
                        load_data     <= mem_read_data;
                        mem_req.read  <= 1'b0;
                        mem_req.write <= 1'b0;
                        lsu_state     <= LSU_DONE;
                    end
                end
                // Held so load_data is still there when the lane writes back
                LSU_DONE: begin
                    if (core_state == CORE_UPDATE) begin
                        lsu_state <= LSU_IDLE;
                    end
                end
                default: lsu_state <= LSU_IDLE;
            endcase
        end
    end

endmodule

/* thread_lane.sv */
// Registers 13 to 15 are read-only identity values; CMP treats operands as signed, arithmetic wraps at 256
`timescale 1ns/1ps
`include "gpu_consts.svh"

module thread_lane import gpu_pkg::*; (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   enable,
    input  core_state_t            core_state,
    input  decoded_t               decoded,
    input  logic [`GPU_ADDR_W-1:0] current_pc,
    input  logic [`GPU_DATA_W-1:0] block_idx,
    input  logic [`GPU_DATA_W-1:0] block_dim,
    input  logic [`GPU_DATA_W-1:0] thread_idx,
    output mem_req_t               mem_req,
    input  logic                   mem_ack,
    input  logic [`GPU_DATA_W-1:0] mem_read_data,
    output lsu_state_t             lsu_state,
    output logic [`GPU_ADDR_W-1:0] next_pc
);

    // First of the three identity registers
    localparam int ID_BASE = `GPU_REGS - 3;

    logic [`GPU_DATA_W-1:0] regs [ID_BASE];
    logic [`GPU_DATA_W-1:0] rs_val;
    logic [`GPU_DATA_W-1:0] rt_val;
    logic [`GPU_DATA_W-1:0] alu_out;
    logic [`GPU_DATA_W-1:0] load_data;
    logic [`GPU_DATA_W-1:0] wb_val;
    logic [`GPU_DATA_W:0]   diff;
    logic [2:0]             cmp_nzp;
    logic [2:0]             nzp;

    function automatic logic [`GPU_DATA_W-1:0] read_reg(input logic [`GPU_REG_IDX_W-1:0] idx);
        case (idx)
            ID_BASE:     return block_idx;
            ID_BASE + 1: return block_dim;
            ID_BASE + 2: return thread_idx;
            default:     return regs[idx];
        endcase
    endfunction

    always_comb begin
        rs_val = read_reg(decoded.rs);
        rt_val = read_reg(decoded.rt);
        // One extra bit keeps the signed difference from overflowing
        diff   = {rs_val[`GPU_DATA_W-1], rs_val} - {rt_val[`GPU_DATA_W-1], rt_val};
    end

    // ALU result and comparison flags are captured in EXECUTE
    always_ff @(posedge clk) begin
        if (core_state == CORE_EXECUTE) begin
            case (decoded.alu_op)
                OP_ADD:  alu_out <= rs_val + rt_val;
                OP_SUB:  alu_out <= rs_val - rt_val;
                OP_MUL:  alu_out <= rs_val * rt_val;
                default: alu_out <= '0;
            endcase
            cmp_nzp <= {diff[`GPU_DATA_W], diff == '0, !diff[`GPU_DATA_W] && diff != '0};
        end
    end

    always_comb begin
        case (decoded.wb_src)
            WB_MEM:  wb_val = load_data;
            WB_IMM:  wb_val = decoded.imm;
            default: wb_val = alu_out;
        endcase
    end

    // Writes to the identity registers are dropped
    always_ff @(posedge clk) begin
        if (core_state == CORE_UPDATE && enable && decoded.reg_write &&
            decoded.rd < ID_BASE) begin
            regs[decoded.rd] <= wb_val;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            nzp <= 3'b000;
        end else if (core_state == CORE_UPDATE && enable && decoded.nzp_write) begin
            nzp <= cmp_nzp;
        end
    end

    // Read in UPDATE, before that cycle's NZP write lands
    assign next_pc = (decoded.branch && |(decoded.nzp & nzp)) ? decoded.imm : current_pc + 1'b1;

    // Address comes from rs, store data from rt
    lsu lsu_inst (
        .clk           (clk),
        .reset         (reset),
        .enable        (enable),
        .core_state    (core_state),
        .decoded       (decoded),
        .address       (rs_val),
        .store_data    (rt_val),
        .mem_req       (mem_req),
        .mem_ack       (mem_ack),
        .mem_read_data (mem_read_data),
        .load_data     (load_data),
        .lsu_state     (lsu_state)
    );

endmodule

/* compute_core.sv */
// block_idx and thread_count must stay stable while a block runs; a new block needs a reset first
`timescale 1ns/1ps
`include "gpu_consts.svh"

module compute_core import gpu_pkg::*; (
    input  logic                                   clk,
    input  logic                                   reset,
    input  logic                                   start,
    input  logic [`GPU_DATA_W-1:0]                 block_idx,
    input  logic [`GPU_DATA_W-1:0]                 thread_count,
    output logic                                   program_read,
    output logic [`GPU_ADDR_W-1:0]                 program_address,
    input  logic                                   program_ack,
    input  logic [`GPU_INSTR_W-1:0]                program_data,
    output mem_req_t [`GPU_LANES-1:0]              data_req,
    input  logic [`GPU_LANES-1:0]                  data_ack,
    input  logic [`GPU_LANES-1:0][`GPU_DATA_W-1:0] data_read_data,
    output core_state_t                            core_state,
    output logic                                   done
);

    logic [`GPU_ADDR_W-1:0]                 current_pc;
    fetch_state_t                           fetch_state;
    logic [`GPU_INSTR_W-1:0]                instruction;
    decoded_t                               decoded;
    lsu_state_t [`GPU_LANES-1:0]            lsu_state;
    logic [`GPU_LANES-1:0][`GPU_ADDR_W-1:0] next_pc;
    logic [`GPU_LANES-1:0]                  lane_enable;

    scheduler scheduler_inst (
        .clk         (clk),
        .reset       (reset),
        .start       (start),
        .decoded_ret (decoded.ret),
        .fetch_state (fetch_state),
        .lsu_state   (lsu_state),
        .lane_enable (lane_enable),
        .next_pc     (next_pc),
        .current_pc  (current_pc),
        .core_state  (core_state),
        .done        (done)
    );

    fetcher fetcher_inst (
        .clk             (clk),
        .reset           (reset),
        .core_state      (core_state),
        .current_pc      (current_pc),
        .program_read    (program_read),
        .program_address (program_address),
        .program_ack     (program_ack),
        .program_data    (program_data),
        .fetch_state     (fetch_state),
        .instruction     (instruction)
    );

    decoder decoder_inst (
        .clk         (clk),
        .reset       (reset),
        .core_state  (core_state),
        .instruction (instruction),
        .decoded     (decoded)
    );

    for (genvar i = 0; i < `GPU_LANES; i++) begin : g_lane
        // Lanes at or above thread_count sit out the whole block
        assign lane_enable[i] = (i < thread_count);

        thread_lane thread_lane_inst (
            .clk           (clk),
            .reset         (reset),
            .enable        (lane_enable[i]),
            .core_state    (core_state),
            .decoded       (decoded),
            .current_pc    (current_pc),
            .block_idx     (block_idx),
            .block_dim     (thread_count),
            .thread_idx    (`GPU_DATA_W'(i)),
            .mem_req       (data_req[i]),
            .mem_ack       (data_ack[i]),
            .mem_read_data (data_read_data[i]),
            .lsu_state     (lsu_state[i]),
            .next_pc       (next_pc[i])
        );
    end

endmodule

/* compute_core_props.sv */
// Bound into compute_core; assumes the memory models answer one request per port at a time
`timescale 1ns/1ps
`include "gpu_consts.svh"

module compute_core_props import gpu_pkg::*; (
    input logic                      clk,
    input logic                      reset,
    input logic                      program_read,
    input logic                      program_ack,
    input mem_req_t [`GPU_LANES-1:0] data_req,
    input logic [`GPU_LANES-1:0]     data_ack,
    input core_state_t               core_state,
    input logic                      done
);

    // Once set, done is cleared only by reset
    done_sticky: assert property (@(posedge clk) (done && !reset) |=> done)
        else $error("done fell without reset");

    program_ack_in_request: assert property (@(posedge clk) disable iff (reset)
        program_ack |-> program_read)
        else $error("program_ack without program_read");

    // Every listed encoding is a real state, so this mostly catches X and Z
    core_state_legal: assert property (@(posedge clk) disable iff (reset)
        !$isunknown(core_state) && core_state inside {CORE_IDLE, CORE_FETCH, CORE_DECODE,
            CORE_REQUEST, CORE_WAIT, CORE_EXECUTE, CORE_UPDATE, CORE_DONE})
        else $error("core_state left its legal encodings");

    for (genvar i = 0; i < `GPU_LANES; i++) begin : g_port
        data_ack_in_request: assert property (@(posedge clk) disable iff (reset)
            data_ack[i] |-> (data_req[i].read || data_req[i].write))
            else $error("data_ack[%0d] without a request", i);

        read_write_exclusive: assert property (@(posedge clk) disable iff (reset)
            !(data_req[i].read && data_req[i].write))
            else $error("data_req[%0d] has read and write set", i);
    end

endmodule

/* compute_core_tb.sv */
// Models both memories with 1 to 4 cycles of latency; the kernel's data layout must match A_BASE to COUNT_ADDR
`timescale 1ns/1ps
`include "gpu_consts.svh"

module compute_core_tb import gpu_pkg::*; ();

    localparam int CLK_PERIOD   = 20;
    localparam int RESET_CYCLES = 4;
    localparam int ENTRY_CYCLES = 1500;
    localparam int NUM_ENTRIES  = 5;
    localparam int KERNEL_LEN   = 23;
    // The constant added once per loop pass
    localparam int K            = 7;
    localparam logic [7:0] A_BASE     = 8'h00;
    localparam logic [7:0] B_BASE     = 8'h40;
    localparam logic [7:0] C_BASE     = 8'h80;
    localparam logic [7:0] COUNT_ADDR = 8'hf0;

    // One test case with the per-lane fields listed from lane 3 down to lane 0
    typedef struct packed {
        logic [7:0]      block_idx;
        logic [7:0]      thread_count;
        logic [7:0]      count;
        logic [3:0][7:0] a;
        logic [3:0][7:0] b;
        logic [3:0][7:0] c;
    } entry_t;

    // Disabled lanes carry 0 in c because their cells keep the preset
    localparam entry_t TABLE [NUM_ENTRIES] = '{
        '{8'd0, 8'd4, 8'd1, {8'd17, 8'd200, 8'd10, 8'd3}, {8'd15, 8'd2, 8'd20, 8'd5},
          {8'(17*15 + K*1), 8'(200*2 + K*1), 8'(10*20 + K*1), 8'(3*5 + K*1)}},
        '{8'd1, 8'd4, 8'd3, {8'd255, 8'd16, 8'd9, 8'd2}, {8'd255, 8'd16, 8'd9, 8'd7},
          {8'(255*255 + K*3), 8'(16*16 + K*3), 8'(9*9 + K*3), 8'(2*7 + K*3)}},
        '{8'd3, 8'd3, 8'd0, {8'd99, 8'd128, 8'd11, 8'd6}, {8'd99, 8'd2, 8'd3, 8'd6},
          {8'd0, 8'(128*2), 8'(11*3), 8'(6*6)}},
        '{8'd5, 8'd1, 8'd2, {8'd1, 8'd1, 8'd1, 8'd12}, {8'd1, 8'd1, 8'd1, 8'd12},
          {8'd0, 8'd0, 8'd0, 8'(12*12 + K*2)}},
        '{8'd1, 8'd2, 8'd3, {8'd5, 8'd5, 8'd1, 8'd100}, {8'd5, 8'd5, 8'd250, 8'd3},
          {8'd0, 8'd0, 8'(1*250 + K*3), 8'(100*3 + K*3)}}
    };

    // Each thread computes C[i] = A[i]*B[i] + K*count where i = block_idx*block_dim + thread_idx
    localparam logic [15:0] KERNEL [KERNEL_LEN] = '{
        16'h50de,  // 0  MUL   r0, r13, r14
        16'h300f,  // 1  ADD   r0, r0, r15
        16'h9100,  // 2  CONST r1, A_BASE
        16'h3110,  // 3  ADD   r1, r1, r0
        16'h7210,  // 4  LDR   r2, [r1]
        16'h9140,  // 5  CONST r1, B_BASE
        16'h3110,  // 6  ADD   r1, r1, r0
        16'h7310,  // 7  LDR   r3, [r1]
        16'h5423,  // 8  MUL   r4, r2, r3
        16'h9507,  // 9  CONST r5, K
        16'h91f0,  // 10 CONST r1, COUNT_ADDR
        16'h7610,  // 11 LDR   r6, [r1]
        16'h9700,  // 12 CONST r7, 0
        16'h9801,  // 13 CONST r8, 1
        16'h2076,  // 14 CMP   r7, r6
        16'h1613,  // 15 BRzp  19
        16'h3445,  // 16 ADD   r4, r4, r5
        16'h3778,  // 17 ADD   r7, r7, r8
        16'h1e0e,  // 18 BRnzp 14
        16'h9180,  // 19 CONST r1, C_BASE
        16'h3110,  // 20 ADD   r1, r1, r0
        16'h8014,  // 21 STR   [r1], r4
        16'hf000   // 22 RET
    };

    logic                                   clk;
    logic                                   reset;
    logic                                   start;
    logic [`GPU_DATA_W-1:0]                 block_idx;
    logic [`GPU_DATA_W-1:0]                 thread_count;
    logic                                   program_read;
    logic [`GPU_ADDR_W-1:0]                 program_address;
    logic                                   program_ack;
    logic [`GPU_INSTR_W-1:0]                program_data;
    mem_req_t [`GPU_LANES-1:0]              data_req;
    logic [`GPU_LANES-1:0]                  data_ack;
    logic [`GPU_LANES-1:0][`GPU_DATA_W-1:0] data_read_data;
    core_state_t                            core_state;
    logic                                   done;

    logic [7:0] data_mem     [256];
    logic [7:0] expected_mem [256];
    int         checks_done;

    compute_core compute_core_inst (.*);

    bind compute_core compute_core_props compute_core_props_inst (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic abort_run();
        $display("Checks failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [15:0] actual,
                               input logic [15:0] expected);
        checks_done++;
        assert (actual === expected) else begin
            $display("[ERROR] %0t %s: got %0h, expected %0h", $time, name, actual, expected);
            abort_run();
        end
    endtask

    // Odd multiplier keeps every address distinct
    function automatic logic [7:0] preset_value(input int addr);
        return 8'(addr * 37) ^ 8'h5a;
    endfunction

    // Fetches past the end of the kernel read RET
    function automatic logic [15:0] kernel_word(input logic [7:0] addr);
        return (addr < KERNEL_LEN) ? KERNEL[addr] : 16'hf000;
    endfunction

    task automatic load_memory(input entry_t e);
        int base;
        for (int addr = 0; addr < 256; addr++) begin
            data_mem[addr] = preset_value(addr);
        end
        data_mem[COUNT_ADDR] = e.count;
        for (int lane = 0; lane < e.thread_count; lane++) begin
            base = e.block_idx * e.thread_count + lane;
            data_mem[A_BASE + base] = e.a[lane];
            data_mem[B_BASE + base] = e.b[lane];
        end
        expected_mem = data_mem;
        // Only enabled threads change memory and each writes its own C cell
        for (int lane = 0; lane < e.thread_count; lane++) begin
            base = e.block_idx * e.thread_count + lane;
            expected_mem[C_BASE + base] = e.c[lane];
        end
    endtask

    // Program and data memories with one countdown per port
    initial begin : memory_models
        logic                   prog_busy;
        int unsigned            prog_wait;
        logic [`GPU_LANES-1:0]  data_busy;
        int unsigned            data_wait [`GPU_LANES];
        void'($urandom(32'h40a7cc11));
        prog_busy = 1'b0;
        data_busy = '0;
        program_ack    <= 1'b0;
        program_data   <= '0;
        data_ack       <= '0;
        data_read_data <= '0;
        forever begin
            @(posedge clk);
            if (reset) begin
                prog_busy = 1'b0;
                data_busy = '0;
                program_ack <= 1'b0;
                data_ack    <= '0;
            end else begin
                program_ack <= 1'b0;
                if (prog_busy) begin
                    if (prog_wait == 0) begin
                        program_ack  <= 1'b1;
                        program_data <= kernel_word(program_address);
                        prog_busy = 1'b0;
                    end else begin
                        prog_wait--;
                    end
                end else if (program_read && !program_ack) begin
                    prog_busy = 1'b1;
                    prog_wait = $urandom_range(3, 0);
                end
                for (int lane = 0; lane < `GPU_LANES; lane++) begin
                    assert (lane < thread_count ||
                            !(data_req[lane].read || data_req[lane].write)) else begin
                        $display("Disabled lane %0d raised a data request at %0t", lane, $time);
                        abort_run();
                    end
                    data_ack[lane] <= 1'b0;
                    if (data_busy[lane]) begin
                        if (data_wait[lane] == 0) begin
                            data_ack[lane]       <= 1'b1;
                            data_read_data[lane] <= data_mem[data_req[lane].address];
                            if (data_req[lane].write) begin
                                data_mem[data_req[lane].address] = data_req[lane].write_data;
                            end
                            data_busy[lane] = 1'b0;
                        end else begin
                            data_wait[lane]--;
                        end
                    end else if ((data_req[lane].read || data_req[lane].write) &&
                                 !data_ack[lane]) begin
                        data_busy[lane] = 1'b1;
                        data_wait[lane] = $urandom_range(3, 0);
                    end
                end
            end
        end
    end

    initial begin : main_sequence
        entry_t e;
        int     cycles;
        checks_done = 0;
        reset        <= 1'b1;
        start        <= 1'b0;
        block_idx    <= '0;
        thread_count <= 8'd1;
        for (int n = 0; n < NUM_ENTRIES; n++) begin
            e = TABLE[n];
            @(posedge clk);
            reset        <= 1'b1;
            block_idx    <= e.block_idx;
            thread_count <= e.thread_count;
            load_memory(e);
            repeat (RESET_CYCLES) @(posedge clk);
            reset <= 1'b0;
            // Reset values are checked before start
            @(negedge clk);
            check_value("done", done, 1'b0);
            check_value("program_read", program_read, 1'b0);
            check_value("core_state", core_state, CORE_IDLE);
            for (int lane = 0; lane < `GPU_LANES; lane++) begin
                check_value($sformatf("data_req[%0d].read", lane), data_req[lane].read, 1'b0);
                check_value($sformatf("data_req[%0d].write", lane), data_req[lane].write, 1'b0);
            end
            @(posedge clk);
            start <= 1'b1;
            @(posedge clk);
            start <= 1'b0;
            cycles = 0;
            while (!done && cycles < ENTRY_CYCLES) begin
                @(negedge clk);
                cycles++;
            end
            assert (done) else begin
                $display("Entry %0d did not finish within %0d cycles", n, ENTRY_CYCLES);
                abort_run();
            end
            // DONE is sticky until the next reset
            repeat (4) begin
                check_value("done", done, 1'b1);
                check_value("core_state", core_state, CORE_DONE);
                @(negedge clk);
            end
            for (int addr = 0; addr < 256; addr++) begin
                check_value($sformatf("data_mem[%02h]", addr), data_mem[addr], expected_mem[addr]);
            end
        end
        if (checks_done > 0) begin
            $display("All checks passed");
        end else begin
            $display("No checks were run");
            $display("Checks failed");
        end
        $finish;
    end

    // Covers every entry at its cycle bound plus reset and the DONE hold
    initial begin : watchdog
        #(NUM_ENTRIES * (ENTRY_CYCLES + 20) * CLK_PERIOD);
        $display("Simulation ran past its time limit");
        abort_run();
    end

endmodule

/* project.f */
+incdir+.
gpu_pkg.sv
scheduler.sv
fetcher.sv
decoder.sv
lsu.sv
thread_lane.sv
compute_core.sv
compute_core_props.sv
compute_core_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Build with Verilator, run, and decide pass or fail from the log
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal -f project.f \
    --top-module compute_core_tb -o compute_core_sim || { echo "Build failed"; exit 1; }

./obj_dir/compute_core_sim > sim.log 2>&1
cat sim.log

grep -q "All checks passed" sim.log && echo "Simulation result: PASS" \
    || { echo "Simulation result: FAIL"; exit 1; }
